// File: Bender.yml
package:
  name: dcache

sources:
  - include_dirs:
      - .
    files:
      - dcache_pkg.sv
      - dcache_tag_array.sv
      - dcache_data_array.sv
      - dcache_ctrl.sv
      - store_buffer.sv
      - backing_mem.sv
      - dcache_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_dcache.sv

// File: backing_mem.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_consts.svh"

module backing_mem (
	input wire logic clock,
	input wire logic reset,
	input wire dcache_pkg::mem_store_t store,
	input wire logic refill_req,
	input wire logic [`DCACHE_MEM_ADDR_W-1:0] refill_addr,
	output logic [`DCACHE_BYTE_W-1:0] rdata,
	output dcache_pkg::bus_grant_e grant,
	output logic store_grant
);
	import dcache_pkg::*;

	localparam int BYTE_W = `DCACHE_BYTE_W;

	logic [BYTE_W-1:0] mem [`DCACHE_MEM_DEPTH];

	// fixed priority, pending stores go first so refills see fresh data
	always_comb begin
		if (store.valid) begin
			grant = GRANT_STORE;
		end else if (refill_req) begin
			grant = GRANT_REFILL;
		end else begin
			grant = GRANT_NONE;
		end
	end

	assign store_grant = (grant == GRANT_STORE);
	assign rdata = mem[refill_addr]; // beat is sampled by the refill engine

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int a = 0; a < `DCACHE_MEM_DEPTH; a++) begin
				mem[a] <= BYTE_W'(2 * a); // wraps modulo 256
			end
		end else if (store_grant) begin
			mem[store.addr] <= store.data;
		end
	end

	store_has_priority: assert property (
		@(posedge clock) disable iff (reset)
		store.valid |-> grant != GRANT_REFILL
	) else $error("refill granted over a pending store");

endmodule

`default_nettype wire

// File: dcache.f
+incdir+.
dcache_pkg.sv
dcache_tag_array.sv
dcache_data_array.sv
dcache_ctrl.sv
store_buffer.sv
backing_mem.sv
dcache_top.sv
tb_dcache.sv

// File: dcache_consts.svh
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// cpu side
`define DCACHE_ADDR_W 32
`define DCACHE_BYTE_W 8

// address split is tag | index | offset
`define DCACHE_TAG_W 24
`define DCACHE_INDEX_W 3
`define DCACHE_OFFSET_W 5

// geometry
`define DCACHE_SETS 8
`define DCACHE_WAYS 2
`define DCACHE_BLOCK_BYTES 32 // also the number of refill beats

// backing memory and write-through path
`define DCACHE_MEM_ADDR_W 10
`define DCACHE_MEM_DEPTH 1024
`define DCACHE_STORE_DEPTH 4

`endif

// File: dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_consts.svh"

module dcache_ctrl (
	input wire logic clock,
	input wire logic reset,
	input wire dcache_pkg::cpu_req_t cpu_req,
	output logic busy,
	output logic [`DCACHE_TAG_W-1:0] tag,
	output logic [`DCACHE_INDEX_W-1:0] index,
	input wire logic hit,
	input wire logic hit_way,
	input wire logic victim_way,
	input wire logic full,
	input wire dcache_pkg::bus_grant_e grant,
	input wire logic [`DCACHE_BYTE_W-1:0] mem_rdata,
	output logic probe_alt,
	output logic fill_done,
	output logic touch_alt,
	output logic push,
	output dcache_pkg::mem_store_t push_data,
	output logic refill_req,
	output logic [`DCACHE_MEM_ADDR_W-1:0] refill_addr,
	output logic wr_en,
	output logic wr_way,
	output logic [`DCACHE_OFFSET_W-1:0] wr_offset,
	output logic [`DCACHE_BYTE_W-1:0] wr_data,
	output logic rd_way,
	output logic [`DCACHE_OFFSET_W-1:0] rd_offset
);
	import dcache_pkg::*;

	localparam int BEAT_W = $clog2(`DCACHE_BLOCK_BYTES) + 1;
	localparam int TAG_LSB = `DCACHE_INDEX_W + `DCACHE_OFFSET_W;

	ctrl_state_e state;
	ctrl_state_e next_state;
	logic [BEAT_W-1:0] beat; // granted refill beats so far
	logic in_refill;
	logic refill_last;
	logic complete;

	assign tag = cpu_req.addr[`DCACHE_ADDR_W-1:TAG_LSB];
	assign index = cpu_req.addr[TAG_LSB-1:`DCACHE_OFFSET_W];
	assign rd_offset = cpu_req.addr[`DCACHE_OFFSET_W-1:0];
	assign rd_way = hit_way;

	assign in_refill = (state == REFILL);
	assign refill_last = (beat == BEAT_W'(`DCACHE_BLOCK_BYTES)); // all beats landed
	assign refill_addr = {cpu_req.addr[`DCACHE_MEM_ADDR_W-1:`DCACHE_OFFSET_W],
		beat[`DCACHE_OFFSET_W-1:0]};

	always_comb begin
		next_state = state;
		probe_alt = (state == LOOKUP_ALT);
		busy = 1'b0;
		complete = 1'b0;
		touch_alt = 1'b0;
		fill_done = 1'b0;
		refill_req = 1'b0;
		case (state)
			LOOKUP_MRU: begin
				if (cpu_req.valid && !hit) begin
					busy = 1'b1;
					next_state = LOOKUP_ALT;
				end else begin
					busy = cpu_req.valid && cpu_req.write && full; // no room for write-through
					complete = cpu_req.valid && !busy;
				end
			end
			LOOKUP_ALT: begin
				if (!cpu_req.valid) begin
					next_state = LOOKUP_MRU;
				end else if (!hit) begin
					busy = 1'b1;
					next_state = REFILL;
				end else begin
					busy = cpu_req.write && full;
					complete = !busy;
					touch_alt = complete;
					if (complete) begin
						next_state = LOOKUP_MRU;
					end
				end
			end
			REFILL: begin
				busy = cpu_req.valid;
				refill_req = !refill_last; // loses to the store buffer until it is empty
				fill_done = refill_last;
				if (refill_last) begin
					next_state = LOOKUP_MRU; // retry now hits the new block
				end
			end
			default: next_state = LOOKUP_MRU;
		endcase
		push = complete && cpu_req.write;
	end

	// refill fills the victim from memory, otherwise the cpu writes its hit way
	assign wr_en = in_refill ? (grant == GRANT_REFILL) : push;
	assign wr_way = in_refill ? victim_way : hit_way;
	assign wr_offset = in_refill ? beat[`DCACHE_OFFSET_W-1:0] : rd_offset;
	assign wr_data = in_refill ? mem_rdata : cpu_req.wdata;

	assign push_data = '{valid: push, addr: cpu_req.addr[`DCACHE_MEM_ADDR_W-1:0],
		data: cpu_req.wdata};

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= LOOKUP_MRU;
			beat <= '0;
		end else begin
			state <= next_state;
			if (refill_last) begin
				beat <= '0;
			end else if (in_refill && grant == GRANT_REFILL) begin
				beat <= beat + 1'b1;
			end
		end
	end

	beat_idle_range: assert property (
		@(posedge clock) disable iff (reset)
		!in_refill |-> beat <= BEAT_W'(`DCACHE_BLOCK_BYTES - 1)
	) else $error("refill beat counter out of range outside REFILL");

endmodule

`default_nettype wire

// File: dcache_data_array.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_consts.svh"

module dcache_data_array (
	input wire logic clock,
	input wire logic wr_en,
	input wire logic wr_way,
	input wire logic [`DCACHE_INDEX_W-1:0] wr_index,
	input wire logic [`DCACHE_OFFSET_W-1:0] wr_offset,
	input wire logic [`DCACHE_BYTE_W-1:0] wr_data,
	input wire logic rd_way,
	input wire logic [`DCACHE_INDEX_W-1:0] rd_index,
	input wire logic [`DCACHE_OFFSET_W-1:0] rd_offset,
	output logic [`DCACHE_BYTE_W-1:0] rd_data
);

	localparam int ADDR_W = 1 + `DCACHE_INDEX_W + `DCACHE_OFFSET_W;
	localparam int ENTRIES = `DCACHE_WAYS * `DCACHE_SETS * `DCACHE_BLOCK_BYTES;

	logic [`DCACHE_BYTE_W-1:0] storage [ENTRIES];
	logic [ADDR_W-1:0] wr_addr;
	logic [ADDR_W-1:0] rd_addr;

	// block number is {way, set}, byte within it is the offset
	assign wr_addr = {wr_way, wr_index, wr_offset};
	assign rd_addr = {rd_way, rd_index, rd_offset};

	always_ff @(posedge clock) begin
		if (wr_en) begin
			storage[wr_addr] <= wr_data;
		end
	end

	assign rd_data = storage[rd_addr]; // same-cycle read for hits

endmodule

`default_nettype wire

// File: dcache_pkg.sv
`default_nettype none
`include "dcache_consts.svh"

package dcache_pkg;

	// request held by the cpu until busy is low at a rising edge
	typedef struct packed {
		logic valid;
		logic write;
		logic [`DCACHE_ADDR_W-1:0] addr;
		logic [`DCACHE_BYTE_W-1:0] wdata;
	} cpu_req_t;

	typedef struct packed {
		logic valid;
		logic [`DCACHE_MEM_ADDR_W-1:0] addr;
		logic [`DCACHE_BYTE_W-1:0] data;
	} mem_store_t;

	typedef enum logic [1:0] {
		LOOKUP_MRU = 2'd0, // probe most recently used way
		LOOKUP_ALT = 2'd1, // probe the other way
		REFILL     = 2'd2
	} ctrl_state_e;

	typedef enum logic [1:0] {
		GRANT_NONE   = 2'd0,
		GRANT_STORE  = 2'd1,
		GRANT_REFILL = 2'd2
	} bus_grant_e;

endpackage

`default_nettype wire

// File: dcache_tag_array.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_consts.svh"

module dcache_tag_array (
	input wire logic clock,
	input wire logic reset,
	input wire logic [`DCACHE_INDEX_W-1:0] index,
	input wire logic [`DCACHE_TAG_W-1:0] tag,
	input wire logic probe_alt,
	input wire logic fill_done,
	input wire logic touch_alt,
	output logic hit,
	output logic hit_way,
	output logic victim_way
);

	logic [`DCACHE_TAG_W-1:0] tags [`DCACHE_WAYS][`DCACHE_SETS];
	logic [`DCACHE_WAYS-1:0][`DCACHE_SETS-1:0] valid;
	logic [`DCACHE_SETS-1:0] mru;
	logic [`DCACHE_SETS-1:0] fifo; // next way to replace

	// one way per cycle, mru first, its partner when probe_alt is set
	assign hit_way = mru[index] ^ probe_alt;
	assign hit = valid[hit_way][index] && (tags[hit_way][index] == tag);
	assign victim_way = fifo[index];

	always_ff @(posedge clock) begin
		if (reset) begin
			valid <= '0;
			mru <= '0;
			fifo <= '0;
		end else if (fill_done) begin
			valid[victim_way][index] <= 1'b1;
			mru[index] <= victim_way; // freshly filled block becomes mru
			fifo[index] <= ~victim_way;
		end else if (touch_alt) begin
			mru[index] <= ~mru[index];
		end
	end

	always_ff @(posedge clock) begin
		if (fill_done) begin
			tags[victim_way][index] <= tag;
		end
	end

	// the controller finishes a refill and an alternate hit in different states
	fill_touch_exclusive: assert property (
		@(posedge clock) disable iff (reset)
		!(fill_done && touch_alt)
	) else $error("fill_done and touch_alt high in the same cycle");

endmodule

`default_nettype wire

// File: dcache_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_consts.svh"

module dcache_top (
	input wire logic clock,
	input wire logic reset,
	input wire dcache_pkg::cpu_req_t cpu_req,
	output logic [`DCACHE_BYTE_W-1:0] rdata,
	output logic busy
);
	import dcache_pkg::*;

	logic [`DCACHE_TAG_W-1:0] tag;
	logic [`DCACHE_INDEX_W-1:0] index;
	logic hit, hit_way, victim_way;
	logic probe_alt, fill_done, touch_alt;
	logic push, full, store_grant;
	mem_store_t push_data;
	mem_store_t head;
	logic refill_req;
	logic [`DCACHE_MEM_ADDR_W-1:0] refill_addr;
	logic [`DCACHE_BYTE_W-1:0] mem_rdata;
	bus_grant_e grant;
	logic wr_en, wr_way, rd_way;
	logic [`DCACHE_OFFSET_W-1:0] wr_offset;
	logic [`DCACHE_OFFSET_W-1:0] rd_offset;
	logic [`DCACHE_BYTE_W-1:0] wr_data;

	dcache_ctrl ctrl (.clock(clock), .reset(reset), .cpu_req(cpu_req), .busy(busy),
		.tag(tag), .index(index), .hit(hit), .hit_way(hit_way), .victim_way(victim_way),
		.full(full), .grant(grant), .mem_rdata(mem_rdata), .probe_alt(probe_alt),
		.fill_done(fill_done), .touch_alt(touch_alt), .push(push), .push_data(push_data),
		.refill_req(refill_req), .refill_addr(refill_addr), .wr_en(wr_en), .wr_way(wr_way),
		.wr_offset(wr_offset), .wr_data(wr_data), .rd_way(rd_way), .rd_offset(rd_offset));

	dcache_tag_array tags (.clock(clock), .reset(reset), .index(index), .tag(tag),
		.probe_alt(probe_alt), .fill_done(fill_done), .touch_alt(touch_alt),
		.hit(hit), .hit_way(hit_way), .victim_way(victim_way));

	dcache_data_array data (.clock(clock), .wr_en(wr_en), .wr_way(wr_way),
		.wr_index(index), .wr_offset(wr_offset), .wr_data(wr_data), .rd_way(rd_way),
		.rd_index(index), .rd_offset(rd_offset), .rd_data(rdata));

	store_buffer stores (.clock(clock), .reset(reset), .push(push), .push_data(push_data),
		.head(head), .full(full), .store_grant(store_grant));

	backing_mem mem (.clock(clock), .reset(reset), .store(head), .refill_req(refill_req),
		.refill_addr(refill_addr), .rdata(mem_rdata), .grant(grant),
		.store_grant(store_grant));

endmodule

`default_nettype wire

// File: store_buffer.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_consts.svh"

module store_buffer #(
	parameter int DEPTH = `DCACHE_STORE_DEPTH
) (
	input wire logic clock,
	input wire logic reset,
	input wire logic push,
	input wire dcache_pkg::mem_store_t push_data,
	output dcache_pkg::mem_store_t head,
	output logic full,
	input wire logic store_grant
);
	import dcache_pkg::*;

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	mem_store_t entries [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	// circular wrap that also works for depths that are not a power of two
	function automatic logic [PTR_W-1:0] bump(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	always_comb begin
		head = entries[rd_ptr];
		head.valid = (count != '0); // oldest store offered first
	end

	assign full = (count == CNT_W'(DEPTH));

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= bump(wr_ptr);
			end
			if (store_grant) begin
				rd_ptr <= bump(rd_ptr);
			end
			case ({push, store_grant})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (push) begin
			entries[wr_ptr] <= push_data;
		end
	end

	// the controller holds a write hit while the buffer is full
	no_push_when_full: assert property (
		@(posedge clock) disable iff (reset)
		full |-> !push
	) else $error("store pushed into a full buffer");

endmodule

`default_nettype wire

// File: tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_consts.svh"

module tb_dcache;
	import dcache_pkg::*;

	localparam logic [1:0] KIND_MRU = 2'd0;
	localparam logic [1:0] KIND_ALT = 2'd1;
	localparam logic [1:0] KIND_MISS = 2'd2;
	localparam int TAG_LSB = `DCACHE_INDEX_W + `DCACHE_OFFSET_W;
	localparam int MISS_CYCLES = 40; // lookup, drain, 32 beats, retry
	localparam int MAX_CYCLES = 120 * MISS_CYCLES + 1200; // misses plus hit traffic
	localparam int RANDOM_ACCESSES = 200;

	logic clock;
	logic reset;
	cpu_req_t cpu_req;
	logic [`DCACHE_BYTE_W-1:0] rdata;
	logic busy;

	logic fresh; // first cycle of the current request
	logic [1:0] kind; // predicted lookup outcome of the current request
	int cycles = 0;

	logic [`DCACHE_BYTE_W-1:0] model [`DCACHE_MEM_DEPTH];
	logic [`DCACHE_TAG_W-1:0] sh_tag [`DCACHE_WAYS][`DCACHE_SETS];
	logic sh_valid [`DCACHE_WAYS][`DCACHE_SETS];
	logic sh_mru [`DCACHE_SETS];
	logic sh_fifo [`DCACHE_SETS];

	dcache_top uut (.clock(clock), .reset(reset), .cpu_req(cpu_req), .rdata(rdata),
		.busy(busy));

	always #2 clock = ~clock;

	task automatic fail_run(input string line);
		$display("%s", line);
		$display("STATUS: FAIL");
		$fatal(1, "run aborted");
	endtask

	task automatic report_mismatch(input string msg);
		fail_run($sformatf("CHECK FAILED at %0t ns: %s", $time, msg));
	endtask

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			fail_run($sformatf("timeout: no end of test after %0d cycles", MAX_CYCLES));
		end
	end

	idle_not_busy: assert property (@(posedge clock) disable iff (reset)
		!cpu_req.valid |-> !busy)
		else report_mismatch("busy high without a request");

	read_matches_model: assert property (@(posedge clock) disable iff (reset)
		cpu_req.valid && !cpu_req.write && !busy |->
			rdata == model[cpu_req.addr[`DCACHE_MEM_ADDR_W-1:0]])
		else report_mismatch($sformatf("read 0x%08h gave 0x%02h, expected 0x%02h",
			$sampled(cpu_req.addr), $sampled(rdata),
			model[$sampled(cpu_req.addr[`DCACHE_MEM_ADDR_W-1:0])]));

	mru_hit_no_stall: assert property (@(posedge clock) disable iff (reset)
		fresh && kind == KIND_MRU |-> !busy)
		else report_mismatch($sformatf("mru hit on 0x%08h stalled",
			$sampled(cpu_req.addr)));

	alt_hit_one_stall: assert property (@(posedge clock) disable iff (reset)
		fresh && kind == KIND_ALT |-> busy ##1 !busy)
		else report_mismatch($sformatf("other-way hit on 0x%08h not one busy cycle",
			$sampled(cpu_req.addr)));

	miss_stalls: assert property (@(posedge clock) disable iff (reset)
		fresh && kind == KIND_MISS |-> busy [*3])
		else report_mismatch($sformatf("miss on 0x%08h did not stall",
			$sampled(cpu_req.addr)));

	function automatic logic [1:0] classify(input logic [`DCACHE_ADDR_W-1:0] addr);
		logic [`DCACHE_INDEX_W-1:0] set;
		logic [`DCACHE_TAG_W-1:0] tag;
		logic way;
		set = addr[TAG_LSB-1:`DCACHE_OFFSET_W];
		tag = addr[`DCACHE_ADDR_W-1:TAG_LSB];
		way = sh_mru[set];
		if (sh_valid[way][set] && sh_tag[way][set] == tag) begin
			return KIND_MRU;
		end
		if (sh_valid[!way][set] && sh_tag[!way][set] == tag) begin
			return KIND_ALT;
		end
		return KIND_MISS;
	endfunction

	// replacement state after the access has completed
	task automatic retire(input logic [`DCACHE_ADDR_W-1:0] addr, input logic [1:0] outcome);
		logic [`DCACHE_INDEX_W-1:0] set;
		logic victim;
		set = addr[TAG_LSB-1:`DCACHE_OFFSET_W];
		victim = sh_fifo[set];
		if (outcome == KIND_ALT) begin
			sh_mru[set] = !sh_mru[set];
		end else if (outcome == KIND_MISS) begin
			sh_tag[victim][set] = addr[`DCACHE_ADDR_W-1:TAG_LSB];
			sh_valid[victim][set] = 1'b1;
			sh_mru[set] = victim; // filled block is probed first next time
			sh_fifo[set] = !victim;
		end
	endtask

	task automatic access(input logic is_write, input logic [`DCACHE_ADDR_W-1:0] addr,
		input logic [`DCACHE_BYTE_W-1:0] wdata);
		logic done;
		logic [1:0] outcome;
		outcome = classify(addr);
		cpu_req = '{valid: 1'b1, write: is_write, addr: addr, wdata: wdata};
		kind = outcome;
		fresh = 1'b1;
		done = 1'b0;
		while (!done) begin
			@(negedge clock);
			done = !busy; // busy has settled mid-cycle
			@(posedge clock);
			#1;
			fresh = 1'b0;
		end
		if (is_write) begin
			model[addr[`DCACHE_MEM_ADDR_W-1:0]] = wdata;
		end
		retire(addr, outcome);
		cpu_req.valid = 1'b0;
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clock);
			#1;
		end
	endtask

	initial begin
		logic [`DCACHE_ADDR_W-1:0] addr;
		logic is_write;
		void'($urandom(32'h750ec7d7));
		clock = 1'b0;
		reset = 1'b1;
		cpu_req = '0;
		fresh = 1'b0;
		kind = KIND_MRU;
		for (int a = 0; a < `DCACHE_MEM_DEPTH; a++) begin
			model[a] = 8'(2 * a);
		end
		for (int s = 0; s < `DCACHE_SETS; s++) begin
			sh_mru[s] = 1'b0;
			sh_fifo[s] = 1'b0;
			for (int w = 0; w < `DCACHE_WAYS; w++) begin
				sh_valid[w][s] = 1'b0;
				sh_tag[w][s] = '0;
			end
		end
		repeat (2) @(posedge clock);
		#1;
		reset = 1'b0;
		idle(3);

		// cold reads
		access(1'b0, 32'h0000_0010, 8'h00);
		access(1'b0, 32'h0000_0047, 8'h00);
		access(1'b0, 32'h0000_031f, 8'h00);
		access(1'b0, 32'h0000_03a2, 8'h00);
		for (int off = 0; off < `DCACHE_BLOCK_BYTES; off += 7) begin
			access(1'b0, 32'h0000_03a0 + off, 8'h00);
		end
		idle(2);

		// write miss allocates and alias reads come from memory
		access(1'b1, 32'h0000_0084, 8'ha5);
		access(1'b0, 32'h0000_0084, 8'h00);
		access(1'b0, 32'h0000_0484, 8'h00);
		access(1'b1, 32'h0000_0550, 8'h3c);
		access(1'b0, 32'h0000_0150, 8'h00);
		access(1'b0, 32'h0000_0550, 8'h00);
		idle(2);

		// three blocks in set 6
		access(1'b0, 32'h0000_00c0, 8'h00);
		access(1'b0, 32'h0000_01c0, 8'h00);
		access(1'b0, 32'h0000_00c3, 8'h00);
		access(1'b0, 32'h0000_02c0, 8'h00);
		access(1'b0, 32'h0000_01c5, 8'h00);
		access(1'b0, 32'h0000_00c7, 8'h00);
		idle(2);

		// write burst deeper than the store buffer, then evict and reread
		for (int i = 0; i < `DCACHE_STORE_DEPTH + 2; i++) begin
			access(1'b1, 32'h0000_03a0 + i, 8'($urandom));
		end
		access(1'b0, 32'h0000_02a3, 8'h00);
		access(1'b0, 32'h0000_01a4, 8'h00);
		access(1'b0, 32'h0000_00a5, 8'h00);
		for (int i = 0; i < `DCACHE_STORE_DEPTH + 2; i++) begin
			access(1'b0, 32'h0000_03a0 + i, 8'h00);
		end
		idle(2);

		// mixed traffic below 0x300 stays clear of the alias blocks above
		for (int n = 0; n < RANDOM_ACCESSES; n++) begin
			addr = $urandom % 768;
			is_write = ($urandom % 3) == 0;
			access(is_write, addr, 8'($urandom));
		end
		idle(4);

		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire
